//--- mmuAccCheck.sv
`timescale 1ns/1ps

module mmuAccCheck
	import mmuAccPkg::*;
(
	input  logic     clock,
	input  logic     rstN,
	input  logic     inValid,
	input  s3_t      in,
	output logic     respValid,
	output mmuResp_t resp
);

	mmuReq_t    req;
	accWord_t   acc;	// page word as looked up
	accMode_t   mode;	// effective mode, possibly from the acl
	vugid_t     vugid;
	logic [3:0] keyValid;
	logic [3:0] grpEq;
	logic [3:0] usrEq;
	logic       usrMatch;
	logic       grpMatch;
	logic [2:0] rights;	// x w r
	logic       usDeny;
	logic       bypass;
	mmuResp_t   nextResp;

	assign req      = in.s2.s1.req;
	assign acc      = in.s2.acc;
	assign mode     = in.mode;
	assign vugid    = in.vugid;
	assign keyValid = in.s2.s1.keyValid;
	assign bypass   = (req.vaddr[31:30] == bypassTop);
	assign usDeny   = acc.base[baseNu] && in.s2.s1.userMode;

	// keyring compare against the effective vugid
	always_comb
	begin
		for (int k = 0; k < 4; k++)
		begin
			grpEq[k] = keyValid[k] && (req.keyring[k].group == vugid.group);
			usrEq[k] = keyValid[k] && (req.keyring[k].user == vugid.user);
		end
	end

	assign usrMatch = |(grpEq & usrEq);	// needs both halves
	assign grpMatch = mode.revGroup ? (|usrEq) : (|grpEq);
	assign rights   = usrMatch ? mode.usr : (grpMatch ? mode.grp : mode.oth);

	always_comb
	begin
		nextResp.paddr = {in.s2.ppage, req.vaddr[11:0]};
		nextResp.hit   = in.s2.hit;
		nextResp.noRwx = '0;
		nextResp.exc   = excNone;

		if (keyValid[0])	// keyring checks need key 0
		begin
			case (mode.krMode)
				2'b00: nextResp.noRwx[flagNx:flagNr] = 3'b111;
				2'b01: nextResp.noRwx[flagNx:flagNr] = ~rights;
				2'b10:
				begin
					if (in.aclUsed)
						nextResp.noRwx[flagNx:flagNr] = ~rights;
					else
						nextResp.exc = excKeyDeny;
				end
				default:
				begin
					if (in.aclUsed || grpMatch)
						nextResp.noRwx[flagNx:flagNr] = ~rights;
					else
						nextResp.exc = excKeyDeny;
				end
			endcase
		end

		// page base flags on top
		nextResp.noRwx[flagNx:flagNr] |= acc.base[2:0] | {3{usDeny}};
		nextResp.noRwx[flagNu]        = usDeny;
		nextResp.noRwx[flagNc]        = acc.noCache;
		nextResp.noRwx[flagHold]      = acc.notReady && acc.noCache;

		if (!in.s2.hit)
		begin
			nextResp.exc   = excTlbMiss;
			nextResp.noRwx = '1;	// nothing allowed on a miss
		end

		if (!in.s2.s1.mmuEnable || bypass)
		begin
			nextResp.paddr = req.vaddr;	// identity
			nextResp.noRwx = '0;
			nextResp.exc   = excNone;
		end
	end

	always_ff @(posedge clock)
	begin
		if (!rstN)
			respValid <= 1'b0;
		else
			respValid <= inValid;
	end

	always_ff @(posedge clock)
	begin
		resp <= nextResp;
	end

endmodule

//--- mmuAccPkg.sv
package mmuAccPkg;

	// noRwx bit positions in the response
	localparam int flagNr   = 0;
	localparam int flagNw   = 1;
	localparam int flagNx   = 2;
	localparam int flagNc   = 3;
	localparam int flagNu   = 4;
	localparam int flagHold = 5;	// not-ready page
	localparam int baseNu   = 3;	// not-user bit inside the page base flags

	localparam logic [15:0] excNone    = 16'h0000;
	localparam logic [15:0] excTlbMiss = 16'hA001;
	localparam logic [15:0] excKeyDeny = 16'hA002;

	localparam logic [1:0] bypassTop = 2'b11;	// va[31:30] of the untranslated window

	typedef enum logic [1:0] {accRead, accWrite, accFetch} accKind_t;	// tag only

	typedef struct packed {
		logic [5:0] group;
		logic [9:0] user;
	} vugid_t;

	// mode and rights, word bits 15:4
	typedef struct packed {
		logic [2:0] oth;	// other triple, x w r
		logic [2:0] grp;	// group triple
		logic [2:0] usr;	// user triple
		logic       revGroup;	// group match taken from user compare
		logic [1:0] krMode;	// 00 deny, 01 keyring, 10 acl, 11 acl or group
	} accMode_t;

	typedef struct packed {
		logic       noCache;	// bit 35
		logic       notReady;	// bit 34
		logic       rsvd;
		logic       aclEnable;	// bit 32
		vugid_t     vugid;	// 31:16
		accMode_t   mode;	// 15:4
		logic [3:0] base;	// nu nx nw nr
	} accWord_t;

	typedef struct packed {
		logic [31:0]  vaddr;
		logic         supMode;	// user access when clear
		logic [1:0]   isr;
		vugid_t [3:0] keyring;	// key 0 in the low bits
		accKind_t     kind;
	} mmuReq_t;

	typedef struct packed {logic valid; logic [19:0] vpage; logic [19:0] ppage; accWord_t acc;} tlbEntry_t;
	typedef struct packed {logic rsvd; logic [2:0] present; accMode_t mode;} aclRepl_t;
	typedef struct packed {aclRepl_t repl; vugid_t key; vugid_t target;} aclEntry_t;
	typedef struct packed {logic [31:0] paddr; logic hit; logic [5:0] noRwx; logic [15:0] exc;} mmuResp_t;

	typedef struct packed {mmuReq_t req; logic mmuEnable; logic userMode; logic [3:0] keyValid;} s1_t;
	typedef struct packed {s1_t s1; logic hit; logic [19:0] ppage; accWord_t acc;} s2_t;
	typedef struct packed {s2_t s2; vugid_t vugid; accMode_t mode; logic aclUsed;} s3_t;

endpackage

//--- mmuAccModel.svh
`ifndef MMU_ACC_MODEL_SVH
`define MMU_ACC_MODEL_SVH

// shadow tables, loaded by the same strobes as the DUT
tlbEntry_t   shadowTlb [8];
aclEntry_t   shadowAcl [4];
logic [15:0] lfsrState = 16'd78;

// 16-bit Fibonacci LFSR, taps 16 15 13 4
function automatic logic lfsrBit();
	logic fb;
	fb        = lfsrState[15] ^ lfsrState[14] ^ lfsrState[12] ^ lfsrState[3];
	lfsrState = {lfsrState[14:0], fb};
	return fb;
endfunction

function automatic logic [31:0] randBits(input int n);
	logic [31:0] v;
	v = '0;
	for (int i = 0; i < n; i++)
	begin
		v = {v[30:0], lfsrBit()};	// one step per bit
	end
	return v;
endfunction

// expected response for one request, from the shadow tables
function automatic mmuResp_t expectedResp(input mmuReq_t r, input logic enable);
	mmuResp_t   e;
	tlbEntry_t  t;
	logic       hit;
	logic [3:0] kv;
	vugid_t     vug;
	accMode_t   md;
	logic       aclUsed;
	logic       found;
	logic       keyHit;
	logic       usrM;
	logic       grpAny;
	logic       usrAny;
	logic       grpM;
	logic [2:0] allow;
	e   = '0;
	t   = '0;
	hit = 1'b0;
	for (int i = 0; i < 8; i++)
	begin
		if (!hit && shadowTlb[i].valid && (shadowTlb[i].vpage == r.vaddr[31:12]))
		begin
			hit = 1'b1;	// lowest slot first
			t   = shadowTlb[i];
		end
	end
	e.hit = hit;
	if (!enable || (r.isr == 2'b11) || (r.vaddr[31:30] == 2'b11))
	begin
		e.paddr = r.vaddr;	// untranslated, no checks
	end
	else if (!hit)
	begin
		e.paddr = {20'h00000, r.vaddr[11:0]};
		e.noRwx = 6'b111111;
		e.exc   = excTlbMiss;
	end
	else
	begin
		for (int k = 0; k < 4; k++)
			kv[k] = (r.keyring[k] != 16'h0000);
		vug     = t.acc.vugid;
		md      = t.acc.mode;
		aclUsed = 1'b0;
		found   = 1'b0;
		for (int i = 0; i < 4; i++)
		begin
			keyHit = 1'b0;
			for (int k = 0; k < 4; k++)
				if (kv[k] && (r.keyring[k] == shadowAcl[i].key))
					keyHit = 1'b1;
			if (!found && keyHit && t.acc.aclEnable && (shadowAcl[i].target == t.acc.vugid))
			begin
				found = 1'b1;
				if (shadowAcl[i].repl.present != 3'b000)
				begin
					vug     = shadowAcl[i].key;	// key takes the page's place
					md      = shadowAcl[i].repl.mode;
					aclUsed = 1'b1;
				end
			end
		end
		usrM   = 1'b0;
		grpAny = 1'b0;
		usrAny = 1'b0;
		for (int k = 0; k < 4; k++)
		begin
			if (kv[k] && (r.keyring[k].group == vug.group))
				grpAny = 1'b1;
			if (kv[k] && (r.keyring[k].user == vug.user))
				usrAny = 1'b1;
			if (kv[k] && (r.keyring[k] == vug))
				usrM = 1'b1;	// both halves
		end
		grpM    = md.revGroup ? usrAny : grpAny;
		allow   = usrM ? md.usr : (grpM ? md.grp : md.oth);
		e.paddr = {t.ppage, r.vaddr[11:0]};
		if (kv[0])
		begin
			case (md.krMode)
				2'b00: e.noRwx[2:0] = 3'b111;
				2'b01: e.noRwx[2:0] = ~allow;
				2'b10:
				begin
					if (aclUsed)
						e.noRwx[2:0] = ~allow;
					else
						e.exc = excKeyDeny;
				end
				default:
				begin
					if (aclUsed || grpM)
						e.noRwx[2:0] = ~allow;
					else
						e.exc = excKeyDeny;
				end
			endcase
		end
		e.noRwx[2:0] = e.noRwx[2:0] | t.acc.base[2:0];
		if (t.acc.base[3] && !r.supMode)
		begin
			e.noRwx[4]   = 1'b1;	// user on a not-user page
			e.noRwx[2:0] = 3'b111;
		end
		e.noRwx[3] = t.acc.noCache;
		e.noRwx[5] = t.acc.notReady && t.acc.noCache;
	end
	return e;
endfunction

`endif

//--- mmuAccTb.sv
`timescale 1ns/1ps

module mmuAccTb
	import mmuAccPkg::*;
();

	localparam int maxCycles = 400;	// tests need about 200 cycles
	localparam vugid_t noKey = '0;

	logic       clock = 1'b0;
	logic       rstN;
	logic       reqValid;
	mmuReq_t    req;
	logic       mmcrEnable;
	logic       tlbWrValid;
	logic [2:0] tlbWrIndex;
	tlbEntry_t  tlbWrEntry;
	logic       aclWrValid;
	logic [1:0] aclWrIndex;
	aclEntry_t  aclWrEntry;
	logic       respValid;
	mmuResp_t   resp;

	mmuResp_t   expQ [$];	// expected responses in issue order
	int         cycles = 0;
	int         checks = 0;
	int         errors = 0;
	int         testErrs = 0;
	accMode_t   allRights;

	`include "mmuAccModel.svh"

	mmuAccTop #(.tlbEntries(8), .aclEntries(4)) i_dut (.*);

	always #4 clock = ~clock;

	always @(posedge clock)
	begin
		cycles <= cycles + 1;
		if (cycles == maxCycles)
		begin
			$display("timeout: run did not finish within %0d cycles", maxCycles);
			$display("TB FAILED");
			$finish;
		end
	end

	// one expected entry popped per respValid
	always @(negedge clock)
	begin
		mmuResp_t want;
		if (rstN && respValid)
		begin
			checks++;
			assert (expQ.size() != 0)
			else
			begin
				$display("unexpected response at %0t with no request outstanding", $time);
				errors++;
			end
			if (expQ.size() != 0)
			begin
				want = expQ.pop_front();
				assert (resp == want)
				else
				begin
					$display("mismatch at %0t: pa %h/%h hit %b/%b f %b/%b exc %h/%h",
						$time, resp.paddr, want.paddr, resp.hit, want.hit,
						resp.noRwx, want.noRwx, resp.exc, want.exc);
					errors++;
				end
			end
		end
	end

	function automatic vugid_t vugidOf(input logic [5:0] g, input logic [9:0] u);
		vugid_t v;
		v.group = g;
		v.user  = u;
		return v;
	endfunction

	function automatic accMode_t modeOf(input logic [1:0] kr, input logic [2:0] usr,
		input logic [2:0] grp, input logic [2:0] oth, input logic rev);
		accMode_t m;
		m.krMode   = kr;
		m.usr      = usr;	// x w r
		m.grp      = grp;
		m.oth      = oth;
		m.revGroup = rev;
		return m;
	endfunction

	function automatic accWord_t pageWord(input accMode_t m, input vugid_t v,
		input logic [3:0] base, input logic acl, input logic nr, input logic nc);
		accWord_t a;
		a           = '0;
		a.mode      = m;
		a.vugid     = v;
		a.base      = base;	// nu nx nw nr
		a.aclEnable = acl;
		a.notReady  = nr;
		a.noCache   = nc;
		return a;
	endfunction

	function automatic mmuReq_t requestFor(input logic [31:0] va, input logic sup,
		input logic [1:0] isr, input vugid_t k0, input vugid_t k1);
		mmuReq_t r;
		r            = '0;
		r.vaddr      = va;
		r.supMode    = sup;
		r.isr        = isr;
		r.keyring[0] = k0;
		r.keyring[1] = k1;
		r.kind       = accRead;
		return r;
	endfunction

	// small key set so random keyrings hit pages and acl entries
	function automatic vugid_t keyPick(input logic [2:0] s);
		vugid_t v;
		case (s)
			3'd0: v = noKey;
			3'd1: v = vugidOf(6'h05, 10'h123);
			3'd2: v = vugidOf(6'h05, 10'h001);
			3'd3: v = vugidOf(6'h06, 10'h001);
			3'd4: v = vugidOf(6'h09, 10'h0BB);
			3'd5: v = vugidOf(6'h02, 10'h0CC);
			3'd6: v = vugidOf(6'h06, 10'h123);
			default: v = vugidOf(6'h07, 10'h0AA);
		endcase
		return v;
	endfunction

	function automatic mmuReq_t randomRequest();
		logic [31:0] rnd;
		logic [19:0] vp;
		mmuReq_t     r;
		rnd = randBits(3);
		case (rnd[2:0])
			3'd0: vp = 20'h00010;
			3'd1: vp = 20'h00020;
			3'd2: vp = 20'h00030;
			3'd3: vp = 20'h00040;
			3'd4: vp = 20'h00050;
			default:
			begin
				rnd = randBits(20);
				vp  = rnd[19:0];	// mostly misses
			end
		endcase
		r       = '0;
		rnd     = randBits(12);
		r.vaddr = {vp, rnd[11:0]};
		rnd     = randBits(2);
		if (rnd[1:0] == 2'b11)
			r.vaddr[31:30] = 2'b11;	// bypass window
		rnd          = randBits(1);
		r.supMode    = rnd[0];
		rnd          = randBits(2);
		r.isr        = rnd[1:0];
		rnd          = randBits(3);
		r.keyring[0] = keyPick(rnd[2:0]);
		rnd          = randBits(3);
		r.keyring[1] = keyPick(rnd[2:0]);
		r.kind       = accFetch;
		return r;
	endfunction

	task automatic writeTlb(input logic [2:0] idx, input logic [19:0] vp,
		input logic [19:0] pp, input accWord_t acc);
		tlbEntry_t e;
		e.valid = 1'b1;
		e.vpage = vp;
		e.ppage = pp;
		e.acc   = acc;
		@(negedge clock);
		tlbWrValid     = 1'b1;
		tlbWrIndex     = idx;
		tlbWrEntry     = e;
		shadowTlb[idx] = e;
		@(negedge clock);
		tlbWrValid = 1'b0;
	endtask

	task automatic writeAcl(input logic [1:0] idx, input vugid_t target, input vugid_t k,
		input logic [2:0] present, input accMode_t m);
		aclEntry_t e;
		e.target       = target;
		e.key          = k;
		e.repl.rsvd    = 1'b0;
		e.repl.present = present;
		e.repl.mode    = m;
		@(negedge clock);
		aclWrValid     = 1'b1;
		aclWrIndex     = idx;
		aclWrEntry     = e;
		shadowAcl[idx] = e;
		@(negedge clock);
		aclWrValid = 1'b0;
	endtask

	// strobe stays high so consecutive calls run back to back
	task automatic issue(input mmuReq_t r);
		@(negedge clock);
		reqValid = 1'b1;
		req      = r;
		expQ.push_back(expectedResp(r, mmcrEnable));
	endtask

	task automatic drain();
		@(negedge clock);
		reqValid = 1'b0;
		while (expQ.size() != 0)
			@(negedge clock);
	endtask

	task automatic endTest(input string name);
		$display("test %s: %0d errors", name, errors - testErrs);
		testErrs = errors;
	endtask

	initial
	begin
		rstN       = 1'b0;
		reqValid   = 1'b0;
		req        = '0;
		mmcrEnable = 1'b0;
		tlbWrValid = 1'b0;
		tlbWrIndex = '0;
		tlbWrEntry = '0;
		aclWrValid = 1'b0;
		aclWrIndex = '0;
		aclWrEntry = '0;
		allRights  = modeOf(2'b01, 3'b111, 3'b111, 3'b111, 1'b0);
		for (int i = 0; i < 8; i++)
			shadowTlb[i] = '0;
		for (int i = 0; i < 4; i++)
			shadowAcl[i] = '0;
		repeat (5) @(negedge clock);
		rstN = 1'b1;

		// idle after reset and identity with the MMU off
		repeat (3)
		begin
			@(negedge clock);
			checks++;
			assert (!respValid)
			else
			begin
				$display("respValid went high after reset with no request");
				errors++;
			end
		end
		issue(requestFor(32'h0001_2345, 1'b0, 2'b00, vugidOf(6'h05, 10'h123), noKey));
		issue(requestFor(32'hC000_0040, 1'b1, 2'b00, noKey, noKey));
		drain();
		endTest("reset and MMU off");

		mmcrEnable = 1'b1;
		writeTlb(3'd3, 20'h00010, 20'h07777, pageWord(allRights, noKey, 4'h0, 1'b0, 1'b0, 1'b0));
		writeTlb(3'd0, 20'h00010, 20'h12345, pageWord(allRights, noKey, 4'h0, 1'b0, 1'b0, 1'b0));
		issue(requestFor(32'h0001_0ABC, 1'b1, 2'b00, noKey, noKey));
		issue(requestFor(32'h0009_9000, 1'b1, 2'b00, noKey, noKey));	// miss
		drain();
		writeTlb(3'd0, 20'h00010, 20'h54321, pageWord(allRights, noKey, 4'h0, 1'b0, 1'b0, 1'b0));
		issue(requestFor(32'h0001_0FFF, 1'b1, 2'b00, noKey, noKey));
		drain();
		endTest("TLB translation");

		writeTlb(3'd1, 20'h00020, 20'h00A20, pageWord(allRights, noKey, 4'h3, 1'b0, 1'b0, 1'b0));
		writeTlb(3'd2, 20'h00030, 20'h00A30, pageWord(allRights, noKey, 4'hC, 1'b0, 1'b1, 1'b1));
		issue(requestFor(32'h0002_0010, 1'b1, 2'b00, noKey, noKey));
		issue(requestFor(32'h0003_0020, 1'b0, 2'b00, noKey, noKey));	// user on NU page
		issue(requestFor(32'h0003_0020, 1'b1, 2'b00, noKey, noKey));
		issue(requestFor(32'h0002_0010, 1'b1, 2'b11, noKey, noKey));	// isr lock
		drain();
		endTest("base flags");

		writeTlb(3'd4, 20'h00040, 20'h00B40, pageWord(modeOf(2'b01, 3'b111, 3'b011, 3'b001, 1'b0),
			vugidOf(6'h05, 10'h123), 4'h0, 1'b0, 1'b0, 1'b0));
		issue(requestFor(32'h0004_0000, 1'b1, 2'b00, vugidOf(6'h05, 10'h123), noKey));
		issue(requestFor(32'h0004_0004, 1'b1, 2'b00, vugidOf(6'h05, 10'h001), noKey));
		issue(requestFor(32'h0004_0008, 1'b1, 2'b00, vugidOf(6'h06, 10'h001), noKey));
		drain();
		writeTlb(3'd4, 20'h00040, 20'h00B40, pageWord(modeOf(2'b01, 3'b111, 3'b011, 3'b001, 1'b1),
			vugidOf(6'h05, 10'h123), 4'h0, 1'b0, 1'b0, 1'b0));
		issue(requestFor(32'h0004_0010, 1'b1, 2'b00, vugidOf(6'h06, 10'h123), noKey));
		issue(requestFor(32'h0004_0014, 1'b1, 2'b00, vugidOf(6'h05, 10'h001), noKey));
		drain();
		writeTlb(3'd4, 20'h00040, 20'h00B40, pageWord(modeOf(2'b00, 3'b111, 3'b011, 3'b001, 1'b0),
			vugidOf(6'h05, 10'h123), 4'h0, 1'b0, 1'b0, 1'b0));
		issue(requestFor(32'h0004_0020, 1'b1, 2'b00, vugidOf(6'h05, 10'h123), noKey));
		drain();
		writeTlb(3'd4, 20'h00040, 20'h00B40, pageWord(modeOf(2'b11, 3'b111, 3'b011, 3'b001, 1'b0),
			vugidOf(6'h05, 10'h123), 4'h0, 1'b0, 1'b0, 1'b0));
		issue(requestFor(32'h0004_0030, 1'b1, 2'b00, vugidOf(6'h06, 10'h001), noKey));	// no group
		issue(requestFor(32'h0004_0034, 1'b1, 2'b00, vugidOf(6'h05, 10'h001), noKey));
		drain();
		endTest("keyring modes");

		writeTlb(3'd5, 20'h00050, 20'h00C50, pageWord(modeOf(2'b10, 3'b000, 3'b000, 3'b000, 1'b0),
			vugidOf(6'h07, 10'h0AA), 4'h0, 1'b1, 1'b0, 1'b0));
		writeAcl(2'd1, vugidOf(6'h07, 10'h0AA), vugidOf(6'h09, 10'h0BB), 3'b001,
			modeOf(2'b10, 3'b101, 3'b000, 3'b000, 1'b0));
		issue(requestFor(32'h0005_0000, 1'b1, 2'b00, vugidOf(6'h09, 10'h0BB), noKey));
		issue(requestFor(32'h0005_0004, 1'b1, 2'b00, vugidOf(6'h03, 10'h003), noKey));	// no entry
		drain();
		writeAcl(2'd0, vugidOf(6'h07, 10'h0AA), vugidOf(6'h02, 10'h0CC), 3'b001,
			modeOf(2'b10, 3'b111, 3'b000, 3'b000, 1'b0));
		issue(requestFor(32'h0005_0008, 1'b1, 2'b00, vugidOf(6'h02, 10'h0CC),
			vugidOf(6'h09, 10'h0BB)));	// both entries apply and slot 0 wins
		drain();
		endTest("ACL override");

		repeat (40) issue(randomRequest());
		drain();
		endTest("random back-to-back");

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

//--- mmuAccTop.f
+incdir+.
mmuAccPkg.sv
mmuReqStage.sv
mmuTlb.sv
mmuAclSelect.sv
mmuAccCheck.sv
mmuAccTop.sv
mmuAcc_props.sv
mmuAccTb.sv

//--- mmuAccTop.sv
`timescale 1ns/1ps

module mmuAccTop
	import mmuAccPkg::*;
#(
	parameter int tlbEntries = 8,
	parameter int aclEntries = 4
)
(
	input  logic                          clock,
	input  logic                          rstN,
	input  logic                          reqValid,
	input  mmuReq_t                       req,
	input  logic                          mmcrEnable,
	input  logic                          tlbWrValid,
	input  logic [$clog2(tlbEntries)-1:0] tlbWrIndex,
	input  tlbEntry_t                     tlbWrEntry,
	input  logic                          aclWrValid,
	input  logic [$clog2(aclEntries)-1:0] aclWrIndex,
	input  aclEntry_t                     aclWrEntry,
	output logic                          respValid,	// reqValid plus four clocks
	output mmuResp_t                      resp
);

	logic s1Valid;
	s1_t  s1;
	logic s2Valid;
	s2_t  s2;
	logic s3Valid;
	s3_t  s3;

	mmuReqStage u_req (.clock(clock), .rstN(rstN), .reqValid(reqValid), .req(req),
		.mmcrEnable(mmcrEnable), .outValid(s1Valid), .out(s1));

	mmuTlb #(.tlbEntries(tlbEntries)) u_tlb (.clock(clock), .rstN(rstN),
		.wrValid(tlbWrValid), .wrIndex(tlbWrIndex), .wrEntry(tlbWrEntry),
		.inValid(s1Valid), .in(s1), .outValid(s2Valid), .out(s2));

	// acl override picked by keyring
	mmuAclSelect #(.aclEntries(aclEntries)) u_acl (.clock(clock), .rstN(rstN),
		.wrValid(aclWrValid), .wrIndex(aclWrIndex), .wrEntry(aclWrEntry),
		.inValid(s2Valid), .in(s2), .outValid(s3Valid), .out(s3));

	mmuAccCheck u_chk (.clock(clock), .rstN(rstN), .inValid(s3Valid), .in(s3),
		.respValid(respValid), .resp(resp));

endmodule

//--- mmuAcc_props.sv
`timescale 1ns/1ps

module mmuAccProps
	import mmuAccPkg::*;
(
	input logic     clock,
	input logic     rstN,
	input logic     reqValid,
	input logic     respValid,
	input mmuResp_t resp
);

	// four register stages between strobe and response
	reqToResp: assert property (@(posedge clock) disable iff (!rstN)
		reqValid |-> ##4 respValid)
		else $error("respValid missing four cycles after reqValid");

	respKnown: assert property (@(posedge clock) disable iff (!rstN)
		respValid |-> !$isunknown(resp))
		else $error("response holds unknown bits while respValid is high");

	// nothing comes out that was not asked for
	respFromReq: assert property (@(posedge clock) disable iff (!rstN)
		respValid |-> $past(reqValid, 4))
		else $error("respValid without a request four cycles earlier");

endmodule

bind mmuAccTop mmuAccProps u_props (.clock(clock), .rstN(rstN), .reqValid(reqValid),
	.respValid(respValid), .resp(resp));

//--- mmuAclSelect.sv
`timescale 1ns/1ps

module mmuAclSelect
	import mmuAccPkg::*;
#(
	parameter int aclEntries = 4
)
(
	input  logic                          clock,
	input  logic                          rstN,
	input  logic                          wrValid,
	input  logic [$clog2(aclEntries)-1:0] wrIndex,
	input  aclEntry_t                     wrEntry,
	input  logic                          inValid,
	input  s2_t                           in,
	output logic                          outValid,
	output s3_t                           out
);

	aclEntry_t       aclMem [aclEntries];
	logic [aclEntries-1:0] applies;	// per entry, target and key both match
	logic            found;
	s3_t             nextOut;

	always_comb
	begin
		for (int i = 0; i < aclEntries; i++)
		begin
			applies[i] = 1'b0;
			for (int k = 0; k < 4; k++)
			begin
				// only populated keys may unlock an entry
				if (in.s1.keyValid[k] && (aclMem[i].key == in.s1.req.keyring[k]))
				begin
					applies[i] = 1'b1;
				end
			end
			applies[i] = applies[i] && in.acc.aclEnable && (aclMem[i].target == in.acc.vugid);
		end
	end

	always_comb
	begin
		found           = 1'b0;
		nextOut.s2      = in;
		nextOut.vugid   = in.acc.vugid;	// page defaults
		nextOut.mode    = in.acc.mode;
		nextOut.aclUsed = 1'b0;
		for (int i = 0; i < aclEntries; i++)
		begin
			if (!found && applies[i])
			begin
				found = 1'b1;	// first hit decides, even with no rights present
				if (aclMem[i].repl.present != '0)
				begin
					nextOut.vugid   = aclMem[i].key;
					nextOut.mode    = aclMem[i].repl.mode;
					nextOut.aclUsed = 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < aclEntries; i++)
			begin
				aclMem[i] <= '0;
			end
			outValid <= 1'b0;
		end
		else
		begin
			if (wrValid)
			begin
				aclMem[wrIndex] <= wrEntry;	// old contents seen this cycle
			end
			outValid <= inValid;
		end
	end

	always_ff @(posedge clock)
	begin
		out <= nextOut;
	end

endmodule

//--- mmuReqStage.sv
`timescale 1ns/1ps

module mmuReqStage
	import mmuAccPkg::*;
(
	input  logic    clock,
	input  logic    rstN,
	input  logic    reqValid,	// one request per strobe
	input  mmuReq_t req,
	input  logic    mmcrEnable,
	output logic    outValid,
	output s1_t     out
);

	logic       isrLock;	// both isr bits set
	logic [3:0] keyValid;
	s1_t        nextOut;

	assign isrLock = &req.isr;	// interrupt handler runs untranslated

	// a zero key marks an empty keyring slot
	always_comb
	begin
		for (int k = 0; k < 4; k++)
		begin
			keyValid[k] = (req.keyring[k] != '0);
		end
	end

	always_comb
	begin
		nextOut.req       = req;
		nextOut.mmuEnable = mmcrEnable && !isrLock;
		nextOut.userMode  = !req.supMode;	// user unless supervisor bit
		nextOut.keyValid  = keyValid;
	end

	// stage valid
	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			outValid <= 1'b0;
		end
		else
		begin
			outValid <= reqValid;
		end
	end

	always_ff @(posedge clock)
	begin
		out <= nextOut;	// taken every cycle, qualified by outValid
	end

endmodule

//--- mmuTlb.sv
`timescale 1ns/1ps

module mmuTlb
	import mmuAccPkg::*;
#(
	parameter int tlbEntries = 8
)
(
	input  logic                          clock,
	input  logic                          rstN,
	input  logic                          wrValid,	// single-cycle load strobe
	input  logic [$clog2(tlbEntries)-1:0] wrIndex,	// slot chosen by the loader
	input  tlbEntry_t                     wrEntry,
	input  logic                          inValid,
	input  s1_t                           in,
	output logic                          outValid,
	output s2_t                           out
);

	tlbEntry_t   tlbMem [tlbEntries];
	logic [19:0] vpage;
	logic        hit;
	logic [19:0] ppage;
	accWord_t    acc;
	s2_t         nextOut;

	assign vpage = in.req.vaddr[31:12];

	// fully associative compare
	always_comb
	begin
		hit   = 1'b0;
		ppage = '0;
		acc   = '0;	// a miss carries an empty word
		// walk downward so the lowest matching slot is left standing
		for (int i = tlbEntries - 1; i >= 0; i--)
		begin
			if (tlbMem[i].valid && (tlbMem[i].vpage == vpage))
			begin
				hit   = 1'b1;
				ppage = tlbMem[i].ppage;
				acc   = tlbMem[i].acc;
			end
		end
	end

	always_comb
	begin
		nextOut.s1    = in;
		nextOut.hit   = hit;
		nextOut.ppage = ppage;
		nextOut.acc   = acc;
	end

	// entry store, write visible on the next lookup
	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < tlbEntries; i++)
			begin
				tlbMem[i] <= '0;	// all slots invalid
			end
		end
		else if (wrValid)
		begin
			tlbMem[wrIndex] <= wrEntry;
		end
	end

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			outValid <= 1'b0;
		end
		else
		begin
			outValid <= inValid;
		end
	end

	always_ff @(posedge clock)
	begin
		out <= nextOut;
	end

endmodule

//--- runSim.sh
#!/usr/bin/env bash
# build the mmuAccTop testbench with Verilator, run it, scan the log
set -eo pipefail

cd "$(dirname "$0")"
rm -f sim.log

verilator --binary --timing --assert \
	-f mmuAccTop.f --top-module mmuAccTb -o mmuAccSim

./obj_dir/mmuAccSim | tee sim.log

if grep -q "TB FAILED" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
echo "simulation clean"
